// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module tb_lsb -Mdir obj_dir
	out=$$(./obj_dir/Vtb_lsb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+.
lsb_pkg.sv
lsb_entry.sv
lsb_alloc.sv
lsb_mem_seq.sv
lsb_top.sv
tb_lsb.sv

// ==== lsb_alloc.sv ====
`timescale 1ns/1ps
`include "lsb_defs.svh"

module lsb_alloc (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  disp_valid,
    input  logic                  retire,
    output logic [`LSB_DEPTH-1:0] alloc_sel,
    output logic                  lsb_full
);

    lsb_pkg::lsb_idx_t     tail;
    logic [`LSB_IDX_W:0]   count;   // 0 .. depth
    logic                  accept;

    assign lsb_full  = count >= (`LSB_IDX_W+1)'(`FULL_LEVEL);
    assign accept    = disp_valid && !lsb_full;   // dropped when full
    assign alloc_sel = accept ? (`LSB_DEPTH'(1) << tail) : '0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;   // wraps with depth a power of two
            end
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== lsb_defs.svh ====
`ifndef LSB_DEFS_SVH
`define LSB_DEFS_SVH

// queue geometry
`define LSB_DEPTH   16
`define LSB_IDX_W   4

// tag zero means the operand has no producer
`define TAG_W       5
`define VAL_W       32
`define ADDR_W      32
`define BYTE_W      8

// full one slot early
`define FULL_LEVEL  15

`endif

// ==== lsb_entry.sv ====
`timescale 1ns/1ps

module lsb_entry (
    input  logic              clk_in,
    input  logic              rst_in,

    input  logic              alloc_en,
    input  logic              release_en,

    input  lsb_pkg::lsb_op_t  in_op,
    input  lsb_pkg::rob_tag_t in_tag,
    input  lsb_pkg::reg_val_t in_rs1_val,
    input  lsb_pkg::rob_tag_t in_rs1_tag,
    input  lsb_pkg::reg_val_t in_rs2_val,
    input  lsb_pkg::rob_tag_t in_rs2_tag,
    input  lsb_pkg::reg_val_t in_imm,

    input  logic              alu_valid,
    input  lsb_pkg::rob_tag_t alu_tag,
    input  lsb_pkg::reg_val_t alu_value,
    input  logic              ld_valid,
    input  lsb_pkg::rob_tag_t ld_tag,
    input  lsb_pkg::reg_val_t ld_value,

    output logic              valid,
    output logic              ready,
    output lsb_pkg::lsb_op_t  op,
    output lsb_pkg::rob_tag_t tag,
    output lsb_pkg::reg_val_t base,
    output lsb_pkg::reg_val_t data,
    output lsb_pkg::reg_val_t imm
);

    lsb_pkg::rob_tag_t rs1_tag;
    lsb_pkg::rob_tag_t rs2_tag;
    lsb_pkg::reg_val_t rs1_val;
    lsb_pkg::reg_val_t rs2_val;
    lsb_pkg::rob_tag_t rs1_tag_nxt;
    lsb_pkg::rob_tag_t rs2_tag_nxt;
    lsb_pkg::reg_val_t rs1_val_nxt;
    lsb_pkg::reg_val_t rs2_val_nxt;

    // resolve one operand against both result buses
    function automatic void wake(
        input  lsb_pkg::rob_tag_t src_tag,
        input  lsb_pkg::reg_val_t src_val,
        output lsb_pkg::rob_tag_t res_tag,
        output lsb_pkg::reg_val_t res_val
    );
        res_tag = src_tag;
        res_val = src_val;
        if (src_tag != '0) begin
            if (alu_valid && alu_tag == src_tag) begin
                res_tag = '0;
                res_val = alu_value;
            end else if (ld_valid && ld_tag == src_tag) begin
                res_tag = '0;
                res_val = ld_value;
            end
        end
    endfunction

    // dispatch cycle snoops the incoming operands
    always_comb begin
        wake(alloc_en ? in_rs1_tag : rs1_tag, alloc_en ? in_rs1_val : rs1_val,
             rs1_tag_nxt, rs1_val_nxt);
        wake(alloc_en ? in_rs2_tag : rs2_tag, alloc_en ? in_rs2_val : rs2_val,
             rs2_tag_nxt, rs2_val_nxt);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            valid <= 1'b0;
        end else if (alloc_en) begin
            valid <= 1'b1;
        end else if (release_en) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (alloc_en) begin
            op  <= in_op;
            tag <= in_tag;
            imm <= in_imm;
        end
        rs1_tag <= rs1_tag_nxt;   // keeps snooping while waiting
        rs1_val <= rs1_val_nxt;
        rs2_tag <= rs2_tag_nxt;
        rs2_val <= rs2_val_nxt;
    end

    assign ready = valid && rs1_tag == '0 && rs2_tag == '0;
    assign base  = rs1_val;
    assign data  = rs2_val;

endmodule

// ==== lsb_mem_seq.sv ====
`timescale 1ns/1ps
`include "lsb_defs.svh"

module lsb_mem_seq (
    input  logic                  clk_in,
    input  logic                  rst_in,
    input  logic                  store_commit,

    input  logic [`LSB_DEPTH-1:0] ent_valid,
    input  logic [`LSB_DEPTH-1:0] ent_ready,
    input  lsb_pkg::lsb_op_t      ent_op   [`LSB_DEPTH],
    input  lsb_pkg::rob_tag_t     ent_tag  [`LSB_DEPTH],
    input  lsb_pkg::reg_val_t     ent_base [`LSB_DEPTH],
    input  lsb_pkg::reg_val_t     ent_data [`LSB_DEPTH],
    input  lsb_pkg::reg_val_t     ent_imm  [`LSB_DEPTH],

    input  lsb_pkg::mem_byte_t    mem_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output lsb_pkg::mem_addr_t    mem_addr,
    output lsb_pkg::mem_byte_t    mem_wdata,

    output logic                  ld_valid,
    output lsb_pkg::rob_tag_t     ld_tag,
    output lsb_pkg::reg_val_t     ld_value,

    output logic [`LSB_DEPTH-1:0] release_sel,
    output logic                  retire
);

    lsb_pkg::lsb_idx_t   head;
    logic [`LSB_IDX_W:0] credits;     // committed stores not yet written
    logic                busy;
    logic [2:0]          byte_left;
    logic [1:0]          byte_idx;
    lsb_pkg::mem_addr_t  addr;
    lsb_pkg::reg_val_t   ld_asm;
    lsb_pkg::reg_val_t   ld_word;
    lsb_pkg::lsb_op_t    head_op;
    logic                head_store;
    logic                can_issue;
    logic                store_done;

    function automatic logic [2:0] op_bytes(input lsb_pkg::lsb_op_t o);
        case (o)
            lsb_pkg::OP_LW, lsb_pkg::OP_SW:                 op_bytes = 3'd4;
            lsb_pkg::OP_LH, lsb_pkg::OP_LHU, lsb_pkg::OP_SH: op_bytes = 3'd2;
            default:                                        op_bytes = 3'd1;
        endcase
    endfunction

    function automatic logic op_is_store(input lsb_pkg::lsb_op_t o);
        op_is_store = o == lsb_pkg::OP_SB || o == lsb_pkg::OP_SH || o == lsb_pkg::OP_SW;
    endfunction

    function automatic lsb_pkg::reg_val_t extend(
        input lsb_pkg::lsb_op_t  o,
        input lsb_pkg::reg_val_t w
    );
        case (o)
            lsb_pkg::OP_LB:  extend = lsb_pkg::reg_val_t'($signed(w[7:0]));
            lsb_pkg::OP_LH:  extend = lsb_pkg::reg_val_t'($signed(w[15:0]));
            lsb_pkg::OP_LBU: extend = lsb_pkg::reg_val_t'(w[7:0]);
            lsb_pkg::OP_LHU: extend = lsb_pkg::reg_val_t'(w[15:0]);
            default:         extend = w;
        endcase
    endfunction

    assign head_op    = ent_op[head];
    assign head_store = op_is_store(head_op);

    // stores wait at the head for a commit credit
    assign can_issue  = !busy && ent_valid[head] && ent_ready[head]
                        && (!head_store || credits != '0);
    assign retire      = busy && byte_left == 3'd1;
    assign store_done  = retire && head_store;
    assign release_sel = retire ? (`LSB_DEPTH'(1) << head) : '0;

    assign mem_req   = busy;
    assign mem_we    = busy && head_store;
    assign mem_addr  = addr;
    assign mem_wdata = ent_data[head][byte_idx*`BYTE_W +: `BYTE_W];   // low byte first

    // read byte arrives with the address, merge it in place
    always_comb begin
        ld_word = ld_asm;
        ld_word[byte_idx*`BYTE_W +: `BYTE_W] = mem_rdata;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            head      <= '0;
            credits   <= '0;
            busy      <= 1'b0;
            byte_left <= '0;
            byte_idx  <= '0;
            ld_valid  <= 1'b0;
        end else begin
            ld_valid <= 1'b0;
            case ({store_commit, store_done})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            if (can_issue) begin
                busy      <= 1'b1;
                byte_left <= op_bytes(head_op);
                byte_idx  <= '0;
            end else if (busy) begin
                byte_left <= byte_left - 1'b1;
                byte_idx  <= byte_idx + 1'b1;
                if (retire) begin
                    busy     <= 1'b0;
                    head     <= head + 1'b1;
                    ld_valid <= !head_store;
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (can_issue) begin
            addr <= ent_base[head] + ent_imm[head];
        end else if (busy) begin
            addr <= addr + 1'b1;
        end
        if (busy && !head_store) begin
            ld_asm <= ld_word;
        end
        if (retire && !head_store) begin
            ld_tag   <= ent_tag[head];
            ld_value <= extend(head_op, ld_word);
        end
    end

endmodule

// ==== lsb_pkg.sv ====
`include "lsb_defs.svh"

package lsb_pkg;

    // load/store micro-op encoding
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } lsb_op_t;

    typedef logic [`TAG_W-1:0]     rob_tag_t;
    typedef logic [`VAL_W-1:0]     reg_val_t;
    typedef logic [`ADDR_W-1:0]    mem_addr_t;
    typedef logic [`BYTE_W-1:0]    mem_byte_t;
    typedef logic [`LSB_IDX_W-1:0] lsb_idx_t;

endpackage

// ==== lsb_top.sv ====
`timescale 1ns/1ps
`include "lsb_defs.svh"

module lsb_top (
    input  logic               clk_in,
    input  logic               rst_in,

    input  logic               disp_valid,
    input  lsb_pkg::lsb_op_t   disp_op,
    input  lsb_pkg::rob_tag_t  disp_tag,
    input  lsb_pkg::reg_val_t  rs1_val,
    input  lsb_pkg::rob_tag_t  rs1_tag,
    input  lsb_pkg::reg_val_t  rs2_val,
    input  lsb_pkg::rob_tag_t  rs2_tag,
    input  lsb_pkg::reg_val_t  imm,

    input  logic               alu_valid,
    input  lsb_pkg::rob_tag_t  alu_tag,
    input  lsb_pkg::reg_val_t  alu_value,

    input  logic               store_commit,

    output logic               mem_req,
    output logic               mem_we,
    output lsb_pkg::mem_addr_t mem_addr,
    output lsb_pkg::mem_byte_t mem_wdata,
    input  lsb_pkg::mem_byte_t mem_rdata,

    output logic               ld_valid,
    output lsb_pkg::rob_tag_t  ld_tag,
    output lsb_pkg::reg_val_t  ld_value,

    output logic               lsb_full
);

    logic [`LSB_DEPTH-1:0] alloc_sel;
    logic [`LSB_DEPTH-1:0] release_sel;
    logic                  retire;

    logic [`LSB_DEPTH-1:0] ent_valid;
    logic [`LSB_DEPTH-1:0] ent_ready;
    lsb_pkg::lsb_op_t      ent_op   [`LSB_DEPTH];
    lsb_pkg::rob_tag_t     ent_tag  [`LSB_DEPTH];
    lsb_pkg::reg_val_t     ent_base [`LSB_DEPTH];
    lsb_pkg::reg_val_t     ent_data [`LSB_DEPTH];
    lsb_pkg::reg_val_t     ent_imm  [`LSB_DEPTH];

    lsb_alloc alloc_i (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .disp_valid (disp_valid),
        .retire     (retire),
        .alloc_sel  (alloc_sel),
        .lsb_full   (lsb_full)
    );

    for (genvar i = 0; i < `LSB_DEPTH; i++) begin : entry_g
        lsb_entry entry_i (
            .clk_in     (clk_in),
            .rst_in     (rst_in),
            .alloc_en   (alloc_sel[i]),
            .release_en (release_sel[i]),
            .in_op      (disp_op),
            .in_tag     (disp_tag),
            .in_rs1_val (rs1_val),
            .in_rs1_tag (rs1_tag),
            .in_rs2_val (rs2_val),
            .in_rs2_tag (rs2_tag),
            .in_imm     (imm),
            .alu_valid  (alu_valid),
            .alu_tag    (alu_tag),
            .alu_value  (alu_value),
            .ld_valid   (ld_valid),   // own load bus fed back
            .ld_tag     (ld_tag),
            .ld_value   (ld_value),
            .valid      (ent_valid[i]),
            .ready      (ent_ready[i]),
            .op         (ent_op[i]),
            .tag        (ent_tag[i]),
            .base       (ent_base[i]),
            .data       (ent_data[i]),
            .imm        (ent_imm[i])
        );
    end

    lsb_mem_seq seq_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .store_commit (store_commit),
        .ent_valid    (ent_valid),
        .ent_ready    (ent_ready),
        .ent_op       (ent_op),
        .ent_tag      (ent_tag),
        .ent_base     (ent_base),
        .ent_data     (ent_data),
        .ent_imm      (ent_imm),
        .mem_rdata    (mem_rdata),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .ld_valid     (ld_valid),
        .ld_tag       (ld_tag),
        .ld_value     (ld_value),
        .release_sel  (release_sel),
        .retire       (retire)
    );

endmodule

// ==== tb_lsb.sv ====
`timescale 1ns/1ps
`include "lsb_defs.svh"

module tb_lsb;

    localparam int NUM_OPS   = 400;
    localparam int MAX_CYCLE = NUM_OPS * 40;

    logic               clk_in;
    logic               rst_in;
    logic               disp_valid;
    lsb_pkg::lsb_op_t   disp_op;
    lsb_pkg::rob_tag_t  disp_tag;
    lsb_pkg::reg_val_t  rs1_val;
    lsb_pkg::rob_tag_t  rs1_tag;
    lsb_pkg::reg_val_t  rs2_val;
    lsb_pkg::rob_tag_t  rs2_tag;
    lsb_pkg::reg_val_t  imm;
    logic               alu_valid;
    lsb_pkg::rob_tag_t  alu_tag;
    lsb_pkg::reg_val_t  alu_value;
    logic               store_commit;
    logic               mem_req;
    logic               mem_we;
    lsb_pkg::mem_addr_t mem_addr;
    lsb_pkg::mem_byte_t mem_wdata;
    lsb_pkg::mem_byte_t mem_rdata;
    logic               ld_valid;
    lsb_pkg::rob_tag_t  ld_tag;
    lsb_pkg::reg_val_t  ld_value;
    logic               lsb_full;

    lsb_pkg::mem_byte_t model_mem [256];   // program-order view
    lsb_pkg::mem_byte_t phys_mem  [256];   // what the DUT touches
    logic [31:0]        seed;
    int                 cycle;
    int                 issued;
    int                 occ;
    int                 occ_after;
    int                 stores_disp;
    int                 commits_sent;
    int                 stores_begun;
    int                 next_tag;
    logic               dv_cur;
    logic               retire_now;
    logic               done;

    logic               alu_pend [32];
    lsb_pkg::reg_val_t  alu_val  [32];
    int                 alu_wait [32];
    logic               ld_pend  [16];
    lsb_pkg::reg_val_t  ld_mval  [16];

    // expected memory cycles and load results in order
    lsb_pkg::mem_addr_t exp_addr  [$];
    logic               exp_we    [$];
    lsb_pkg::mem_byte_t exp_wdata [$];
    logic               exp_first [$];
    logic               exp_last  [$];
    lsb_pkg::rob_tag_t  exp_ltag  [$];
    lsb_pkg::reg_val_t  exp_lval  [$];

    // next values for the DUT inputs
    logic               n_disp;
    lsb_pkg::lsb_op_t   n_op;
    lsb_pkg::rob_tag_t  n_tag;
    lsb_pkg::reg_val_t  n_rs1_val;
    lsb_pkg::rob_tag_t  n_rs1_tag;
    lsb_pkg::reg_val_t  n_rs2_val;
    lsb_pkg::rob_tag_t  n_rs2_tag;
    lsb_pkg::reg_val_t  n_imm;
    logic               n_alu;
    lsb_pkg::rob_tag_t  n_alu_tag;
    lsb_pkg::reg_val_t  n_alu_val;
    logic               n_commit;

    lsb_top lsb_top_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .disp_valid   (disp_valid),
        .disp_op      (disp_op),
        .disp_tag     (disp_tag),
        .rs1_val      (rs1_val),
        .rs1_tag      (rs1_tag),
        .rs2_val      (rs2_val),
        .rs2_tag      (rs2_tag),
        .imm          (imm),
        .alu_valid    (alu_valid),
        .alu_tag      (alu_tag),
        .alu_value    (alu_value),
        .store_commit (store_commit),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .ld_valid     (ld_valid),
        .ld_tag       (ld_tag),
        .ld_value     (ld_value),
        .lsb_full     (lsb_full)
    );

    always #2 clk_in = ~clk_in;

    assign mem_rdata = phys_mem[mem_addr[7:0]];   // same-cycle read

    always @(posedge clk_in) begin
        if (mem_req && mem_we) begin
            phys_mem[mem_addr[7:0]] <= mem_wdata;
        end
    end

    function automatic int unsigned rand_below(input int unsigned n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 8) % n;
    endfunction

    function automatic lsb_pkg::reg_val_t rand_word();
        return lsb_pkg::reg_val_t'({16'(rand_below(65536)), 16'(rand_below(65536))});
    endfunction

    function automatic lsb_pkg::mem_byte_t fill_byte(input int a);
        return lsb_pkg::mem_byte_t'(a * 167 + 13);
    endfunction

    task automatic report_failure(input string what);
        $display("%s at %0t", what, $time);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input lsb_pkg::mem_byte_t exp,
                              input lsb_pkg::mem_byte_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input lsb_pkg::mem_addr_t exp,
                              input lsb_pkg::mem_addr_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_tag(input string name, input lsb_pkg::rob_tag_t exp,
                             input lsb_pkg::rob_tag_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_val(input string name, input lsb_pkg::reg_val_t exp,
                             input lsb_pkg::reg_val_t act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // random scan for an alu tag that is pending (want=1) or free
    function automatic int find_alu(input logic want);
        int unsigned start;
        int          t;
        start = rand_below(16);
        find_alu = 0;
        for (int i = 0; i < 16; i++) begin
            t = 16 + int'((start + i) % 16);
            if (find_alu == 0 && alu_pend[t] == want) begin
                find_alu = t;
            end
        end
    endfunction

    function automatic int find_load();
        int unsigned start;
        int          t;
        start = rand_below(15);
        find_load = 0;
        for (int i = 0; i < 15; i++) begin
            t = 1 + int'((start + i) % 15);
            if (find_load == 0 && ld_pend[t]) begin
                find_load = t;
            end
        end
    endfunction

    task automatic make_operand(output lsb_pkg::rob_tag_t t, output lsb_pkg::reg_val_t dut_v,
                                output lsb_pkg::reg_val_t model_v);
        int unsigned kind;
        int          tg;
        kind = rand_below(10);
        tg = 0;
        dut_v = rand_word();
        model_v = dut_v;
        t = '0;
        if (kind == 6) begin
            tg = find_alu(1'b1);
        end else if (kind == 7) begin
            tg = find_alu(1'b0);
            if (tg != 0) begin   // new producer
                alu_pend[tg] = 1'b1;
                alu_val[tg] = rand_word();
                alu_wait[tg] = int'(rand_below(9));
            end
        end else if (kind >= 8) begin
            tg = find_load();
        end
        if (tg >= 16) begin
            t = lsb_pkg::rob_tag_t'(tg);
            model_v = alu_val[tg];
        end else if (tg > 0) begin
            t = lsb_pkg::rob_tag_t'(tg);
            model_v = ld_mval[tg];
        end
    endtask

    task automatic make_op();
        lsb_pkg::reg_val_t  b;
        lsb_pkg::reg_val_t  d;
        lsb_pkg::reg_val_t  w;
        lsb_pkg::mem_addr_t a;
        lsb_pkg::mem_addr_t ak;
        int                 n;
        logic               st;
        n_op = lsb_pkg::lsb_op_t'(rand_below(8));
        make_operand(n_rs1_tag, n_rs1_val, b);
        make_operand(n_rs2_tag, n_rs2_val, d);
        n_imm = lsb_pkg::reg_val_t'(rand_below(64));
        n_tag = lsb_pkg::rob_tag_t'(next_tag);
        a = b + n_imm;
        case (n_op)
            lsb_pkg::OP_LW, lsb_pkg::OP_SW:                  n = 4;
            lsb_pkg::OP_LH, lsb_pkg::OP_LHU, lsb_pkg::OP_SH: n = 2;
            default:                                         n = 1;
        endcase
        st = n_op == lsb_pkg::OP_SB || n_op == lsb_pkg::OP_SH || n_op == lsb_pkg::OP_SW;
        w = '0;
        for (int k = 0; k < n; k++) begin
            ak = a + lsb_pkg::mem_addr_t'(k);
            exp_addr.push_back(ak);
            exp_we.push_back(st);
            exp_first.push_back(k == 0);
            exp_last.push_back(k == n - 1);
            if (st) begin
                model_mem[ak[7:0]] = d[8*k +: 8];
                exp_wdata.push_back(d[8*k +: 8]);
            end else begin
                w[8*k +: 8] = model_mem[ak[7:0]];
                exp_wdata.push_back('0);
            end
        end
        if (st) begin
            stores_disp++;
        end else begin
            case (n_op)
                lsb_pkg::OP_LB:  w = {{24{w[7]}}, w[7:0]};
                lsb_pkg::OP_LH:  w = {{16{w[15]}}, w[15:0]};
                lsb_pkg::OP_LBU: w = {24'h0, w[7:0]};
                lsb_pkg::OP_LHU: w = {16'h0, w[15:0]};
                default:         w = w;
            endcase
            exp_ltag.push_back(n_tag);
            exp_lval.push_back(w);
            ld_pend[next_tag] = 1'b1;
            ld_mval[next_tag] = w;
        end
        next_tag = next_tag == 15 ? 1 : next_tag + 1;
        issued++;
        n_disp = 1'b1;
    endtask

    task automatic check_outputs();
        retire_now = 1'b0;
        if (mem_req) begin
            if (exp_addr.size() == 0) begin
                report_failure("memory request with no access pending");
            end else begin
                check_addr("mem_addr", exp_addr[0], mem_addr);
                check_bit("mem_we", exp_we[0], mem_we);
                if (exp_we[0]) begin
                    check_byte("mem_wdata", exp_wdata[0], mem_wdata);
                    if (exp_first[0]) begin
                        stores_begun++;
                    end
                end
                retire_now = exp_last[0];
                void'(exp_addr.pop_front());
                void'(exp_we.pop_front());
                void'(exp_wdata.pop_front());
                void'(exp_first.pop_front());
                void'(exp_last.pop_front());
            end
        end
        if (stores_begun > commits_sent) begin
            report_failure("a store was written before it was committed");
        end
        if (ld_valid) begin
            if (exp_ltag.size() == 0) begin
                report_failure("load result with no load pending");
            end else begin
                check_tag("ld_tag", exp_ltag[0], ld_tag);
                check_val("ld_value", exp_lval[0], ld_value);
                ld_pend[exp_ltag[0]] = 1'b0;   // now seen on the bus
                void'(exp_ltag.pop_front());
                void'(exp_lval.pop_front());
            end
        end
        check_bit("lsb_full", occ >= `FULL_LEVEL, lsb_full);
    endtask

    task automatic plan_cycle();
        int   bt;
        logic withhold;
        bt = 0;
        n_disp = 1'b0;
        n_alu = 1'b0;
        n_commit = 1'b0;
        occ_after = occ + int'(dv_cur) - int'(retire_now);
        if (issued < NUM_OPS && occ_after < `FULL_LEVEL && rand_below(4) != 0) begin
            make_op();
        end
        for (int t = 16; t < 32; t++) begin
            if (alu_pend[t]) begin
                if (alu_wait[t] == 0 && bt == 0) begin
                    bt = t;
                end else if (alu_wait[t] > 0) begin
                    alu_wait[t]--;
                end
            end
        end
        if (bt != 0) begin
            n_alu = 1'b1;
            n_alu_tag = lsb_pkg::rob_tag_t'(bt);
            n_alu_val = alu_val[bt];
            alu_pend[bt] = 1'b0;
        end
        // starve the head store now and then so the queue fills
        withhold = issued < NUM_OPS && (cycle / 256) % 4 == 2;
        if (!withhold && stores_disp > commits_sent && rand_below(3) == 0) begin
            n_commit = 1'b1;
            commits_sent++;
        end
    endtask

    initial begin
        clk_in = 1'b0;
        rst_in = 1'b1;
        disp_valid = 1'b0;
        disp_op = lsb_pkg::OP_LB;
        disp_tag = '0;
        rs1_val = '0;
        rs1_tag = '0;
        rs2_val = '0;
        rs2_tag = '0;
        imm = '0;
        alu_valid = 1'b0;
        alu_tag = '0;
        alu_value = '0;
        store_commit = 1'b0;
        n_disp = 1'b0;
        n_op = lsb_pkg::OP_LB;
        n_tag = '0;
        n_rs1_val = '0;
        n_rs1_tag = '0;
        n_rs2_val = '0;
        n_rs2_tag = '0;
        n_imm = '0;
        n_alu = 1'b0;
        n_alu_tag = '0;
        n_alu_val = '0;
        n_commit = 1'b0;
        seed = 32'h3eca;
        cycle = 0;
        issued = 0;
        occ = 0;
        stores_disp = 0;
        commits_sent = 0;
        stores_begun = 0;
        next_tag = 1;
        dv_cur = 1'b0;
        done = 1'b0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = fill_byte(i);
            phys_mem[i] = fill_byte(i);
        end
        for (int i = 0; i < 32; i++) begin
            alu_pend[i] = 1'b0;
            alu_val[i] = '0;
            alu_wait[i] = 0;
        end
        for (int i = 0; i < 16; i++) begin
            ld_pend[i] = 1'b0;
            ld_mval[i] = '0;
        end
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        check_bit("mem_req", 1'b0, mem_req);
        check_bit("ld_valid", 1'b0, ld_valid);
        check_bit("lsb_full", 1'b0, lsb_full);
        while (!done) begin
            @(negedge clk_in);
            check_outputs();
            done = issued == NUM_OPS && exp_addr.size() == 0 && exp_ltag.size() == 0
                   && occ == 0 && !dv_cur;
            plan_cycle();
            @(posedge clk_in);
            disp_valid <= n_disp;
            disp_op <= n_op;
            disp_tag <= n_tag;
            rs1_val <= n_rs1_val;
            rs1_tag <= n_rs1_tag;
            rs2_val <= n_rs2_val;
            rs2_tag <= n_rs2_tag;
            imm <= n_imm;
            alu_valid <= n_alu;
            alu_tag <= n_alu_tag;
            alu_value <= n_alu_val;
            store_commit <= n_commit;
            occ = occ_after;
            dv_cur = n_disp;
            cycle++;
            if (cycle > MAX_CYCLE) begin
                $display("timeout: the run did not finish within %0d cycles", MAX_CYCLE);
                $display("Errors found");
                $fatal(1);
            end
        end
        $display("No errors");
        $finish;
    end

endmodule
